/* design/stage2_cnn_pkg.sv */
`default_nettype none

package stage2_cnn_pkg;

	// ============================================================
	// window geometry
	// ============================================================
	localparam int KX = 5;
	localparam int KY = 5;

	// ============================================================
	// datapath widths
	// ============================================================
	// signed feature map pixel
	localparam int I_BW = 8;
	// signed weight
	localparam int W_BW = 8;
	// one pixel * weight product
	localparam int M_BW = 16;
	// kernel sum, 5 guard bits for the 25 terms
	localparam int AK_BW = 21;
	// channel sum, room for up to 8 channels
	localparam int AC_BW = 24;
	localparam int B_BW = 24;
	// output pixel
	localparam int O_BW = 8;

	// ============================================================
	// element and window types
	// ============================================================
	typedef logic signed [I_BW-1:0] fpix_t;
	typedef logic signed [W_BW-1:0] wgt_t;
	typedef logic signed [M_BW-1:0] prod_t;

	// row-major, element index is row*KX+col
	typedef fpix_t [KY*KX-1:0] fmap_win_t;
	typedef wgt_t [KY*KX-1:0] weight_win_t;

	typedef logic signed [AK_BW-1:0] kacc_t;
	typedef logic signed [AC_BW-1:0] cacc_t;
	typedef logic signed [O_BW-1:0] pix_t;

	// ============================================================
	// per-layer settings
	// ============================================================
	typedef enum logic {
		ACT_NONE = 1'b0,
		ACT_RELU = 1'b1
	} act_mode_e;

	typedef struct packed {
		logic signed [B_BW-1:0] bias;
		// arithmetic right shift, 0..15
		logic [3:0] shift;
		act_mode_e act;
	} layer_cfg_t;

endpackage

`default_nettype wire

/* design/stage2_cnn_kernel.sv */
`timescale 1ns/100ps
`default_nettype none

module stage2_cnn_kernel
	import stage2_cnn_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_in_valid,
	input wire fmap_win_t i_in_fmap,
	input wire weight_win_t i_cnn_weight,
	output logic o_ot_valid,
	output kacc_t o_ot_kernel_acc
);

	// products, row sums, total
	localparam int LATENCY = 3;

	// ============================================================
	// valid pipeline
	// ============================================================
	// bit 0 qualifies the products, bit 1 the row sums
	logic [LATENCY-1:0] r_valid;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= '0;
		end else begin
			r_valid <= {r_valid[LATENCY-2:0], i_in_valid};
		end
	end

	assign o_ot_valid = r_valid[LATENCY-1];

	// ============================================================
	// stage 1: 25 parallel products
	// ============================================================
	prod_t [KY*KX-1:0] mul;
	prod_t [KY*KX-1:0] r_mul;

	// both operands sign extended before the multiply
	always_comb begin
		for (int k = 0; k < KY*KX; k++) begin
			mul[k] = prod_t'(i_in_fmap[k]) * prod_t'(i_cnn_weight[k]);
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_mul <= '0;
		end else if (i_in_valid) begin
			r_mul <= mul;
		end
	end

	// ============================================================
	// stage 2: one partial sum per window row
	// ============================================================
	kacc_t [KY-1:0] row_sum;
	kacc_t [KY-1:0] r_row_sum;

	always_comb begin
		for (int r = 0; r < KY; r++) begin
			row_sum[r] = '0;
			// widen each product to the kernel width
			for (int c = 0; c < KX; c++) begin
				row_sum[r] = row_sum[r] + kacc_t'(r_mul[r*KX+c]);
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_row_sum <= '0;
		end else if (r_valid[0]) begin
			r_row_sum <= row_sum;
		end
	end

	// ============================================================
	// stage 3: kernel total
	// ============================================================
	kacc_t kern_sum;
	kacc_t r_kern_sum;

	always_comb begin
		kern_sum = '0;
		for (int r = 0; r < KY; r++) begin
			kern_sum = kern_sum + r_row_sum[r];
		end
	end

	// 25 terms of at most 2^14 fit in AK_BW, no overflow here
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_kern_sum <= '0;
		end else if (r_valid[1]) begin
			r_kern_sum <= kern_sum;
		end
	end

	assign o_ot_kernel_acc = r_kern_sum;

endmodule

`default_nettype wire

/* design/stage2_cnn_channel_sum.sv */
`timescale 1ns/100ps
`default_nettype none

module stage2_cnn_channel_sum
	import stage2_cnn_pkg::*;
#(
	// input channels, 1..8
	parameter int ICH = 3
) (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_valid,
	input wire kacc_t [ICH-1:0] i_kacc,
	output logic o_valid,
	output cacc_t o_cacc
);

	// ============================================================
	// cross-channel adder
	// ============================================================
	// one flat sum, ICH stays small
	cacc_t chan_sum;

	always_comb begin
		chan_sum = '0;
		for (int ch = 0; ch < ICH; ch++) begin
			// kacc_t is signed so the cast sign extends
			chan_sum = chan_sum + cacc_t'(i_kacc[ch]);
		end
	end

	// ============================================================
	// output register
	// ============================================================
	logic r_valid;
	cacc_t r_cacc;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_valid;
		end
	end

	// data holds between valid cycles
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_cacc <= '0;
		end else if (i_valid) begin
			r_cacc <= chan_sum;
		end
	end

	assign o_valid = r_valid;
	assign o_cacc = r_cacc;

endmodule

`default_nettype wire

/* design/stage2_cnn_bias_act.sv */
`timescale 1ns/100ps
`default_nettype none

module stage2_cnn_bias_act
	import stage2_cnn_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_valid,
	input wire cacc_t i_cacc,
	input wire layer_cfg_t i_cfg,
	output logic o_valid,
	output pix_t o_pix
);

	// wider of the two operands plus one guard bit
	localparam int S_BW = ((AC_BW > B_BW) ? AC_BW : B_BW) + 1;

	localparam pix_t PIX_MAX = {1'b0, {(O_BW-1){1'b1}}};
	localparam pix_t PIX_MIN = {1'b1, {(O_BW-1){1'b0}}};

	// ============================================================
	// bias, activation, shift
	// ============================================================
	logic signed [S_BW-1:0] biased;
	logic signed [S_BW-1:0] act_val;
	logic signed [S_BW-1:0] shifted;
	// bits above the output msb, incl. the msb itself
	logic [S_BW-O_BW:0] upper;
	pix_t sat_pix;

	always_comb begin
		biased = S_BW'(i_cacc) + S_BW'(i_cfg.bias);

		// relu clamps negatives before the shift
		if (i_cfg.act == ACT_RELU && biased[S_BW-1]) begin
			act_val = '0;
		end else begin
			act_val = biased;
		end

		shifted = act_val >>> i_cfg.shift;

		// in range when all upper bits agree with the sign
		upper = shifted[S_BW-1:O_BW-1];
		if (upper == '0 || upper == '1) begin
			sat_pix = shifted[O_BW-1:0];
		end else if (shifted[S_BW-1]) begin
			sat_pix = PIX_MIN;
		end else begin
			sat_pix = PIX_MAX;
		end
	end

	// ============================================================
	// output register
	// ============================================================
	logic r_valid;
	pix_t r_pix;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_valid;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_pix <= '0;
		end else if (i_valid) begin
			r_pix <= sat_pix;
		end
	end

	assign o_valid = r_valid;
	assign o_pix = r_pix;

endmodule

`default_nettype wire

/* design/stage2_cnn_core.sv */
`timescale 1ns/100ps
`default_nettype none

module stage2_cnn_core
	import stage2_cnn_pkg::*;
#(
	// input channels, 1..8
	parameter int ICH = 3
) (
	input wire logic clk,
	input wire logic reset_n,
	// one window set per valid cycle, no back-pressure
	input wire logic i_valid,
	input wire fmap_win_t [ICH-1:0] i_fmap,
	input wire weight_win_t [ICH-1:0] i_weight,
	// held stable for the whole layer
	input wire layer_cfg_t i_cfg,
	output logic o_valid,
	output pix_t o_pix
);

	// ============================================================
	// per-channel kernels, 3 cycles
	// ============================================================
	logic [ICH-1:0] kern_valid;
	kacc_t [ICH-1:0] kern_acc;

	for (genvar ch = 0; ch < ICH; ch++) begin : g_kernel
		stage2_cnn_kernel u_stage2_cnn_kernel (
			.clk (clk),
			.reset_n (reset_n),
			.i_in_valid (i_valid),
			.i_in_fmap (i_fmap[ch]),
			.i_cnn_weight (i_weight[ch]),
			.o_ot_valid (kern_valid[ch]),
			.o_ot_kernel_acc (kern_acc[ch])
		);
	end

	// ============================================================
	// channel sum, 1 cycle
	// ============================================================
	// kernels run in lockstep, channel 0 valid stands for all
	logic sum_valid;
	cacc_t sum_cacc;

	stage2_cnn_channel_sum #(
		.ICH (ICH)
	) u_stage2_cnn_channel_sum (
		.clk (clk),
		.reset_n (reset_n),
		.i_valid (kern_valid[0]),
		.i_kacc (kern_acc),
		.o_valid (sum_valid),
		.o_cacc (sum_cacc)
	);

	// ============================================================
	// bias and activation, 1 cycle
	// ============================================================
	// total input to output latency is 5 cycles
	stage2_cnn_bias_act u_stage2_cnn_bias_act (
		.clk (clk),
		.reset_n (reset_n),
		.i_valid (sum_valid),
		.i_cacc (sum_cacc),
		.i_cfg (i_cfg),
		.o_valid (o_valid),
		.o_pix (o_pix)
	);

endmodule

`default_nettype wire

/* dv/stage2_cnn_core_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module stage2_cnn_core_assertions
	import stage2_cnn_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_in_valid,
	input wire logic i_out_valid,
	input wire pix_t i_out_pix
);

	localparam int LATENCY = 5;

	// edges since reset release, stops at LATENCY
	logic [2:0] warm_cnt;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			warm_cnt <= '0;
		end else if (warm_cnt != 3'(LATENCY)) begin
			warm_cnt <= warm_cnt + 3'd1;
		end
	end

	// ============================================================
	// concurrent checks
	// ============================================================
	a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !i_out_valid)
		else $error("o_valid high while reset is asserted");

	// history must cover LATENCY edges after reset
	a_latency: assert property (@(posedge clk) disable iff (!reset_n)
		(warm_cnt == 3'(LATENCY)) |-> (i_out_valid == $past(i_in_valid, LATENCY)))
		else $error("o_valid does not follow i_valid by the pipeline latency");

	a_pix_known: assert property (@(posedge clk) disable iff (!reset_n)
		i_out_valid |-> !$isunknown(i_out_pix))
		else $error("o_pix carries unknown bits while o_valid is high");

endmodule

bind stage2_cnn_core stage2_cnn_core_assertions u_stage2_cnn_core_assertions (
	.clk (clk),
	.reset_n (reset_n),
	.i_in_valid (i_valid),
	.i_out_valid (o_valid),
	.i_out_pix (o_pix)
);

`default_nettype wire

/* dv/stage2_cnn_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module stage2_cnn_core_tb
	import stage2_cnn_pkg::*;
();

	localparam int ICH = 3;
	// input sampling edge to output edge
	localparam int LATENCY = 5;
	localparam int N_ENTRIES = 18;
	localparam int DRAIN_TIMEOUT = 50;
	// marker for a gap drawn from the random stream
	localparam logic [3:0] GAP_RANDOM = 4'hf;

	typedef fmap_win_t [ICH-1:0] fmap_set_t;
	typedef weight_win_t [ICH-1:0] weight_set_t;

	typedef enum logic [1:0] {
		FILL_RANDOM,
		FILL_MAX,
		FILL_MIN,
		FILL_EXPLICIT
	} fill_e;

	// one stimulus line where px and wt matter only for FILL_EXPLICIT
	typedef struct packed {
		layer_cfg_t cfg;
		fill_e fill;
		fpix_t px;
		wgt_t wt;
		logic [3:0] gap;
		pix_t expected;
	} entry_t;

	typedef struct packed {
		pix_t pix;
		int due;
	} pending_t;

	logic clk = 1'b0;
	logic reset_n;
	logic i_valid;
	fmap_set_t i_fmap;
	weight_set_t i_weight;
	layer_cfg_t i_cfg;
	logic o_valid;
	pix_t o_pix;

	entry_t stim [N_ENTRIES];
	fmap_set_t stim_fmap [N_ENTRIES];
	weight_set_t stim_weight [N_ENTRIES];
	pending_t pending [$];
	logic [31:0] rng = 32'hd673;
	int cyc = 0;

	stage2_cnn_core #(
		.ICH (ICH)
	) u_stage2_cnn_core (
		.clk (clk),
		.reset_n (reset_n),
		.i_valid (i_valid),
		.i_fmap (i_fmap),
		.i_weight (i_weight),
		.i_cfg (i_cfg),
		.o_valid (o_valid),
		.o_pix (o_pix)
	);

	// 8 ns period
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// ============================================================
	// reference model and helpers
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// dot product then bias, relu, arithmetic shift and saturation
	function automatic pix_t model_pix(input fmap_set_t f, input weight_set_t w,
			input layer_cfg_t cfg);
		longint acc;
		acc = 0;
		for (int ch = 0; ch < ICH; ch++) begin
			for (int k = 0; k < KY*KX; k++) begin
				acc = acc + longint'(f[ch][k]) * longint'(w[ch][k]);
			end
		end
		acc = acc + longint'(cfg.bias);
		if (cfg.act == ACT_RELU && acc < 0) begin
			acc = 0;
		end
		acc = acc >>> cfg.shift;
		if (acc > 127) begin
			return pix_t'(127);
		end else if (acc < -128) begin
			return pix_t'(-128);
		end
		return pix_t'(acc);
	endfunction

	function automatic entry_t build_entry(input int bias, input int shift, input act_mode_e act,
			input fill_e fill, input int px, input int wt, input int gap);
		entry_t e;
		e.cfg.bias = B_BW'(bias);
		e.cfg.shift = 4'(shift);
		e.cfg.act = act;
		e.fill = fill;
		e.px = fpix_t'(px);
		e.wt = wgt_t'(wt);
		e.gap = 4'(gap);
		e.expected = '0;
		return e;
	endfunction

	// ============================================================
	// error reporting
	// ============================================================
	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "stopping simulation at first error");
	endtask

	task automatic report_error(input string reason);
		$display("ERROR time=%0t %s", $time, reason);
		abort_run();
	endtask

	task automatic compare_pix(input string name, input pix_t exp_val, input pix_t got_val);
		if (got_val !== exp_val) begin
			$display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
				$time, name, exp_val, got_val);
			abort_run();
		end
	endtask

	// o_valid must land on the exact cycle
	task automatic compare_valid(input string name, input int exp_cyc, input int got_cyc);
		if (got_cyc != exp_cyc) begin
			$display("MISMATCH time=%0t signal=%s expected=cycle %0d actual=cycle %0d",
				$time, name, exp_cyc, got_cyc);
			abort_run();
		end
	endtask

	// ============================================================
	// stimulus table
	// ============================================================
	task automatic load_table();
		// small random windows with plain pass-through
		stim[0] = build_entry(3, 0, ACT_NONE, FILL_RANDOM, 0, 0, 0);
		stim[1] = build_entry(3, 0, ACT_NONE, FILL_RANDOM, 0, 0, 0);
		stim[2] = build_entry(3, 0, ACT_NONE, FILL_RANDOM, 0, 0, 0);
		stim[3] = build_entry(3, 0, ACT_NONE, FILL_RANDOM, 0, 0, GAP_RANDOM);
		stim[4] = build_entry(3, 0, ACT_NONE, FILL_RANDOM, 0, 0, 2);
		// negative sums clamp to zero under relu
		stim[5] = build_entry(100, 0, ACT_RELU, FILL_EXPLICIT, 10, -3, 0);
		stim[6] = build_entry(100, 0, ACT_RELU, FILL_EXPLICIT, 4, -5, 1);
		// same windows without relu
		stim[7] = build_entry(100, 5, ACT_NONE, FILL_EXPLICIT, 10, -3, 0);
		stim[8] = build_entry(100, 5, ACT_NONE, FILL_EXPLICIT, 4, -5, 0);
		stim[9] = build_entry(100, 0, ACT_NONE, FILL_EXPLICIT, 10, -3, 0);
		// extremes saturate and then get scaled down
		stim[10] = build_entry(0, 0, ACT_NONE, FILL_MAX, 0, 0, 0);
		stim[11] = build_entry(0, 0, ACT_NONE, FILL_MIN, 0, 0, 0);
		stim[12] = build_entry(0, 15, ACT_NONE, FILL_MAX, 0, 0, 0);
		stim[13] = build_entry(0, 15, ACT_NONE, FILL_MIN, 0, 0, 1);
		// random gaps with mixed sign around zero
		stim[14] = build_entry(-20, 1, ACT_RELU, FILL_RANDOM, 0, 0, GAP_RANDOM);
		stim[15] = build_entry(-20, 1, ACT_RELU, FILL_RANDOM, 0, 0, GAP_RANDOM);
		stim[16] = build_entry(-20, 1, ACT_RELU, FILL_RANDOM, 0, 0, GAP_RANDOM);
		stim[17] = build_entry(-20, 1, ACT_RELU, FILL_RANDOM, 0, 0, GAP_RANDOM);
	endtask

	// build windows, random gaps and expected pixels before the run
	task automatic prepare_stimulus();
		for (int idx = 0; idx < N_ENTRIES; idx++) begin
			for (int ch = 0; ch < ICH; ch++) begin
				for (int k = 0; k < KY*KX; k++) begin
					case (stim[idx].fill)
						FILL_RANDOM: begin
							rng = xorshift32(rng);
							// values in -2..1 keep sums near the output range
							stim_fmap[idx][ch][k] = fpix_t'($signed(rng[1:0]));
							stim_weight[idx][ch][k] = wgt_t'($signed(rng[3:2]));
						end
						FILL_MAX: begin
							stim_fmap[idx][ch][k] = fpix_t'(127);
							stim_weight[idx][ch][k] = wgt_t'(127);
						end
						FILL_MIN: begin
							stim_fmap[idx][ch][k] = fpix_t'(-128);
							stim_weight[idx][ch][k] = wgt_t'(127);
						end
						default: begin
							stim_fmap[idx][ch][k] = stim[idx].px;
							stim_weight[idx][ch][k] = stim[idx].wt;
						end
					endcase
				end
			end
			if (stim[idx].gap == GAP_RANDOM) begin
				rng = xorshift32(rng);
				stim[idx].gap = 4'(rng % 6);
			end
			stim[idx].expected = model_pix(stim_fmap[idx], stim_weight[idx], stim[idx].cfg);
		end
	endtask

	// ============================================================
	// driver and monitor
	// ============================================================
	task automatic apply_entry(input int idx);
		pending_t item;
		@(posedge clk);
		i_valid <= 1'b1;
		i_fmap <= stim_fmap[idx];
		i_weight <= stim_weight[idx];
		item.pix = stim[idx].expected;
		// cyc holds the pre-edge count and the DUT samples one edge later
		item.due = cyc + LATENCY + 1;
		pending.push_back(item);
		repeat (stim[idx].gap) begin
			@(posedge clk);
			i_valid <= 1'b0;
		end
	endtask

	// cfg may only change with nothing in flight
	task automatic drain_pipeline();
		int waited;
		waited = 0;
		@(posedge clk);
		i_valid <= 1'b0;
		while (pending.size() != 0) begin
			@(posedge clk);
			waited = waited + 1;
			if (waited > DRAIN_TIMEOUT) begin
				report_error("pipeline did not drain, outputs still missing after timeout");
			end
		end
	endtask

	// sample mid-cycle away from the driving edge
	always @(negedge clk) begin
		pending_t item;
		if (reset_n) begin
			if (o_valid) begin
				if (pending.size() == 0) begin
					report_error("o_valid went high with no input in flight");
				end else begin
					item = pending.pop_front();
					compare_valid("o_valid", item.due, cyc);
					compare_pix("o_pix", item.pix, o_pix);
				end
			end else if (pending.size() != 0 && cyc > pending[0].due) begin
				report_error("o_valid did not arrive at the expected cycle");
			end
		end
	end

	initial begin
		reset_n = 1'b0;
		i_valid = 1'b0;
		i_fmap = '0;
		i_weight = '0;
		i_cfg = '0;
		load_table();
		prepare_stimulus();
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		// idle after reset so the monitor sees any stray output
		repeat (4) @(posedge clk);
		for (int idx = 0; idx < N_ENTRIES; idx++) begin
			if (idx == 0 || stim[idx].cfg != stim[idx-1].cfg) begin
				drain_pipeline();
				@(posedge clk);
				i_cfg <= stim[idx].cfg;
			end
			apply_entry(idx);
		end
		drain_pipeline();
		repeat (4) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* stage2_cnn_core.f */
design/stage2_cnn_pkg.sv
design/stage2_cnn_kernel.sv
design/stage2_cnn_channel_sum.sv
design/stage2_cnn_bias_act.sv
design/stage2_cnn_core.sv
dv/stage2_cnn_core_assertions.sv
dv/stage2_cnn_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the stage2_cnn_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f stage2_cnn_core.f \
	--top-module stage2_cnn_core_tb \
	--Mdir obj_dir \
	-o sim_stage2_cnn_core

sim_out=$(./obj_dir/sim_stage2_cnn_core 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "^TEST OK$"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
